// ==== Makefile ====
# Verilator build for the core and its testbench

TOP = tb_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f files.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== core_pkg.sv ====
/*
 * Core package
 * Widths, RV32I encodings, the operation type and the stage payloads
 */

package core_pkg;

    // Data and address width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // First fetch address out of reset
    localparam word_t reset_pc  = '0;
    // ADDI x0,x0,0
    localparam word_t nop_instr = 32'h0000_0013;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // Funct3 of the kept instructions
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_sw      = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    // Funct7 of register ops
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    ////////////////////////////////////////////////////////////////////////////
    // Operations and payloads
    ////////////////////////////////////////////////////////////////////////////

    // Zero encoding is nop, the bubble of both stage registers
    typedef enum logic [3:0] {
        op_nop, op_add, op_sub, op_and, op_or, op_xor,
        op_slt, op_lui, op_store, op_beq, op_bne
    } op_e;

    // Decode to execute
    typedef struct packed {
        op_e       op;
        word_t     pc;
        word_t     operand_a;
        word_t     operand_b;
        word_t     store_data;
        word_t     branch_target;
        reg_addr_t rd;
        logic      writes;
    } exec_bundle_t;

    // Execute to retire
    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      writes;
    } retire_bundle_t;

endpackage

// ==== core_stimulus.mem ====
// Program word count, then one instruction word per line from address 0
// Expected store count, then one store per line as address and data
00000019
00500093  // 00 addi x1, x0, 5
00308113  // 04 addi x2, x1, 3
002081B3  // 08 add  x3, x1, x2
04302023  // 0c sw   x3, 0x40(x0)
40208233  // 10 sub  x4, x1, x2
001222B3  // 14 slt  x5, x4, x1
00524333  // 18 xor  x6, x4, x5
04602223  // 1c sw   x6, 0x44(x0)
123453B7  // 20 lui  x7, 0x12345
6783E393  // 24 ori  x7, x7, 0x678
04702423  // 28 sw   x7, 0x48(x0)
00208463  // 2c beq  x1, x2, +8 falls through
0F03F413  // 30 andi x8, x7, 0x0f0
04802623  // 34 sw   x8, 0x4c(x0)
00209663  // 38 bne  x1, x2, +12 taken
04102823  // 3c sw   x1, 0x50(x0) skipped
04202A23  // 40 sw   x2, 0x54(x0) skipped
0051E4B3  // 44 or   x9, x3, x5
FFF3C513  // 48 xori x10, x7, -1
009575B3  // 4c and  x11, x10, x9
04B02823  // 50 sw   x11, 0x50(x0)
00000463  // 54 beq  x0, x0, +8 taken
04902A23  // 58 sw   x9, 0x54(x0) skipped
04A02C23  // 5c sw   x10, 0x58(x0)
00000063  // 60 beq  x0, x0, 0 self loop
00000006
00000040 0000000D
00000044 FFFFFFFC
00000048 12345678
0000004C 00000070
00000050 00000005
00000058 EDCBA987

// ==== core_top.sv ====
/*
 * Core top level
 * Four stage RV32I subset core wiring fetch, decode, execute and retire
 */

`timescale 1ns/10ps

module core_top
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  stall_i,
    input  word_t instruction_i,
    output word_t instruction_address_o,
    output logic  mem_write_o,
    output word_t mem_address_o,
    output word_t mem_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage signals
    ////////////////////////////////////////////////////////////////////////////

    // Fetch to decode
    word_t          instruction_decode;
    word_t          pc_decode;

    // Decode and bank
    reg_addr_t      rs1;
    reg_addr_t      rs2;
    word_t          rs1_data;
    word_t          rs2_data;
    logic           uses_rs1;
    logic           uses_rs2;
    exec_bundle_t   exec_d;
    exec_bundle_t   exec_q;

    // Execute and retire
    retire_bundle_t retire_d;
    retire_bundle_t retire_q;
    reg_addr_t      exec_rd;
    logic           exec_writes;
    logic           branch_taken;
    word_t          branch_target;

    // Control
    logic           enable_fetch;
    logic           flush_decode;
    logic           bubble_exec;
    logic           hold;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////////////////////

    fetch_stage fetch_1 (
        .clk                  (clk),
        .reset_n              (reset_n),
        .enable_i             (enable_fetch),
        .flush_i              (flush_decode),
        .redirect_i           (branch_taken),
        .redirect_target_i    (branch_target),
        .instruction_i        (instruction_i),
        .instruction_address_o(instruction_address_o),
        .instruction_o        (instruction_decode),
        .pc_o                 (pc_decode)
    );

    decode_stage decode_1 (
        .instruction_i(instruction_decode),
        .pc_i         (pc_decode),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .uses_rs1_o   (uses_rs1),
        .uses_rs2_o   (uses_rs2),
        .bundle_o     (exec_d)
    );

    // Written from the retire register
    register_bank bank_1 (
        .clk           (clk),
        .reset_n       (reset_n),
        .write_enable_i(retire_q.writes),
        .write_addr_i  (retire_q.rd),
        .write_data_i  (retire_q.result),
        .read_addr1_i  (rs1),
        .read_addr2_i  (rs2),
        .read_data1_o  (rs1_data),
        .read_data2_o  (rs2_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute and retire
    ////////////////////////////////////////////////////////////////////////////

    stage_reg #(.payload_t(exec_bundle_t)) exec_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .hold_i  (hold),
        .bubble_i(bubble_exec),
        .data_i  (exec_d),
        .data_o  (exec_q)
    );

    execute_stage execute_1 (
        .bundle_i       (exec_q),
        .result_o       (retire_d),
        .rd_o           (exec_rd),
        .writes_o       (exec_writes),
        .branch_taken_o (branch_taken),
        .branch_target_o(branch_target),
        .mem_write_o    (mem_write_o),
        .mem_address_o  (mem_address_o),
        .mem_data_o     (mem_data_o)
    );

    // Retire never needs a bubble
    stage_reg #(.payload_t(retire_bundle_t)) retire_reg (
        .clk     (clk),
        .reset_n (reset_n),
        .hold_i  (hold),
        .bubble_i(1'b0),
        .data_i  (retire_d),
        .data_o  (retire_q)
    );

    pipeline_control control_1 (
        .stall_i       (stall_i),
        .rs1_i         (rs1),
        .rs2_i         (rs2),
        .uses_rs1_i    (uses_rs1),
        .uses_rs2_i    (uses_rs2),
        .exec_rd_i     (exec_rd),
        .exec_writes_i (exec_writes),
        .branch_taken_i(branch_taken),
        .enable_fetch_o(enable_fetch),
        .flush_decode_o(flush_decode),
        .bubble_exec_o (bubble_exec),
        .hold_o        (hold)
    );

endmodule

// ==== decode_stage.sv ====
/*
 * Decode stage
 * Field split, immediates, operation select and the execute payload
 */

`timescale 1ns/10ps

module decode_stage
    import core_pkg::*;
(
    input  word_t        instruction_i,
    input  word_t        pc_i,
    input  word_t        rs1_data_i,
    input  word_t        rs2_data_i,
    output reg_addr_t    rs1_o,
    output reg_addr_t    rs2_o,
    output logic         uses_rs1_o,
    output logic         uses_rs2_o,
    output exec_bundle_t bundle_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    op_e        op;

    ////////////////////////////////////////////////////////////////////////////
    // Fields and immediates
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = instruction_i[6:0];
    assign rd     = instruction_i[11:7];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];

    // Sign always from bit 31
    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    // Anything not matched stays nop
    always_comb begin
        op = op_nop;
        case (opcode)
            opc_op: begin
                if (funct7 == f7_sub && funct3 == f3_add_sub) begin
                    op = op_sub;
                end
                else if (funct7 == f7_base) begin
                    case (funct3)
                        f3_add_sub: op = op_add;
                        f3_slt:     op = op_slt;
                        f3_xor:     op = op_xor;
                        f3_or:      op = op_or;
                        f3_and:     op = op_and;
                        default:    op = op_nop;
                    endcase
                end
            end
            // No SLTI in this core
            opc_op_imm: begin
                case (funct3)
                    f3_add_sub: op = op_add;
                    f3_xor:     op = op_xor;
                    f3_or:      op = op_or;
                    f3_and:     op = op_and;
                    default:    op = op_nop;
                endcase
            end
            opc_lui:   op = op_lui;
            opc_store: op = (funct3 == f3_sw) ? op_store : op_nop;
            opc_branch: begin
                case (funct3)
                    f3_beq:  op = op_beq;
                    f3_bne:  op = op_bne;
                    default: op = op_nop;
                endcase
            end
            default: op = op_nop;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload and source usage
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        bundle_o               = '0;
        bundle_o.op            = op;
        bundle_o.pc            = pc_i;
        bundle_o.operand_a     = rs1_data_i;
        bundle_o.operand_b     = rs2_data_i;
        bundle_o.store_data    = rs2_data_i;
        bundle_o.branch_target = pc_i + imm_b;
        bundle_o.rd            = rd;
        uses_rs1_o             = 1'b0;
        uses_rs2_o             = 1'b0;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
                // Writes to x0 are dropped here already
                bundle_o.writes = rd != '0;
                uses_rs1_o      = 1'b1;
                uses_rs2_o      = opcode == opc_op;
                if (opcode == opc_op_imm) begin
                    bundle_o.operand_b = imm_i;
                end
            end
            op_lui: begin
                bundle_o.operand_b = imm_u;
                bundle_o.writes    = rd != '0;
            end
            // Address base in operand_a, offset in operand_b
            op_store: begin
                bundle_o.operand_b = imm_s;
                uses_rs1_o         = 1'b1;
                uses_rs2_o         = 1'b1;
            end
            op_beq, op_bne: begin
                uses_rs1_o = 1'b1;
                uses_rs2_o = 1'b1;
            end
            default: bundle_o.writes = 1'b0;
        endcase
    end

endmodule

// ==== execute_stage.sv ====
/*
 * Execute stage
 * ALU, branch compare, store port and the retire payload
 */

`timescale 1ns/10ps

module execute_stage
    import core_pkg::*;
(
    input  exec_bundle_t   bundle_i,
    output retire_bundle_t result_o,
    output reg_addr_t      rd_o,
    output logic           writes_o,
    output logic           branch_taken_o,
    output word_t          branch_target_o,
    output logic           mem_write_o,
    output word_t          mem_address_o,
    output word_t          mem_data_o
);

    word_t a;
    word_t b;
    word_t sum;
    word_t alu_result;
    logic  equal;

    assign a = bundle_i.operand_a;
    assign b = bundle_i.operand_b;

    // One adder for ADD, ADDI and the store address
    assign sum   = a + b;
    assign equal = a == b;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (bundle_i.op)
            op_add:  alu_result = sum;
            op_sub:  alu_result = a - b;
            op_and:  alu_result = a & b;
            op_or:   alu_result = a | b;
            op_xor:  alu_result = a ^ b;
            // Signed compare
            op_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            // Upper immediate already shifted in decode
            op_lui:  alu_result = b;
            default: alu_result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch and store
    ////////////////////////////////////////////////////////////////////////////

    assign branch_taken_o  = (bundle_i.op == op_beq && equal) ||
                             (bundle_i.op == op_bne && !equal);
    assign branch_target_o = bundle_i.branch_target;

    // Word store only
    assign mem_write_o   = bundle_i.op == op_store;
    assign mem_address_o = {sum[xlen-1:2], 2'b00};
    assign mem_data_o    = bundle_i.store_data;

    // Hazard view for control
    assign rd_o     = bundle_i.rd;
    assign writes_o = bundle_i.writes;

    assign result_o = '{result: alu_result, rd: bundle_i.rd, writes: bundle_i.writes};

    // Write flag is built in decode
    always_comb begin
        store_no_write: assert final (!(mem_write_o && bundle_i.writes))
            else $error("store carries a register write");
    end

endmodule

// ==== fetch_stage.sv ====
/*
 * Fetch stage
 * Program counter with branch redirect and the instruction register toward decode
 */

`timescale 1ns/10ps

module fetch_stage
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  enable_i,
    input  logic  flush_i,
    input  logic  redirect_i,
    input  word_t redirect_target_i,
    input  word_t instruction_i,
    output word_t instruction_address_o,
    output word_t instruction_o,
    output word_t pc_o
);

    word_t pc;
    word_t pc_next;

    // Taken branch wins over the sequential step
    assign pc_next = redirect_i ? redirect_target_i : pc + 32'd4;

    // ROM is asynchronous so the pc goes straight out
    assign instruction_address_o = pc;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= reset_pc;
        end
        else if (enable_i) begin
            pc <= pc_next;
        end
    end

    // Decode side register
    // Flushed slot becomes ADDI x0,x0,0
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= nop_instr;
            pc_o          <= reset_pc;
        end
        else if (enable_i) begin
            instruction_o <= flush_i ? nop_instr : instruction_i;
            pc_o          <= pc;
        end
    end

    // Targets come from decode through execute, so check alignment here
    pc_aligned: assert property (@(posedge clk) disable iff (!reset_n) pc[1:0] == 2'b00)
        else $error("fetch pc %h not word aligned", pc);

endmodule

// ==== files.f ====
core_pkg.sv
stage_reg.sv
fetch_stage.sv
decode_stage.sv
register_bank.sv
execute_stage.sv
pipeline_control.sv
core_top.sv
tb_core.sv

// ==== pipeline_control.sv ====
/*
 * Pipeline control
 * Hazard stall, branch flush and external stall for all stages
 */

`timescale 1ns/10ps

module pipeline_control
    import core_pkg::*;
(
    input  logic      stall_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  logic      uses_rs1_i,
    input  logic      uses_rs2_i,
    input  reg_addr_t exec_rd_i,
    input  logic      exec_writes_i,
    input  logic      branch_taken_i,
    output logic      enable_fetch_o,
    output logic      flush_decode_o,
    output logic      bubble_exec_o,
    output logic      hold_o
);

    logic hazard_rs1;
    logic hazard_rs2;
    logic hazard;

    // Read after write against execute only
    // Retire conflicts resolve in the bank write-through
    assign hazard_rs1 = uses_rs1_i && rs1_i != '0 && rs1_i == exec_rd_i;
    assign hazard_rs2 = uses_rs2_i && rs2_i != '0 && rs2_i == exec_rd_i;
    assign hazard     = exec_writes_i && (hazard_rs1 || hazard_rs2);

    // External stall freezes everything
    assign hold_o = stall_i;

    // Fetch and decode wait on a hazard
    assign enable_fetch_o = !stall_i && !hazard;

    // NOP into execute for a hazard or a taken branch
    assign bubble_exec_o = !stall_i && (hazard || branch_taken_i);

    // Kill the slot fetched behind the branch
    assign flush_decode_o = !stall_i && branch_taken_i;

    // Redirect needs fetch enabled
    // A branch in execute carries no write flag and never raises a hazard
    always_comb begin
        branch_no_write: assert final (!(branch_taken_i && exec_writes_i))
            else $error("taken branch in execute carries a register write");
    end

endmodule

// ==== register_bank.sv ====
/*
 * Register bank
 * x1 to x31 with two combinational read ports and write-through
 */

`timescale 1ns/10ps

module register_bank
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      write_enable_i,
    input  reg_addr_t write_addr_i,
    input  word_t     write_data_i,
    input  reg_addr_t read_addr1_i,
    input  reg_addr_t read_addr2_i,
    output word_t     read_data1_o,
    output word_t     read_data2_o
);

    // No storage behind x0
    word_t regs [1:31];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end
        else if (write_enable_i && write_addr_i != '0) begin
            regs[write_addr_i] <= write_data_i;
        end
    end

    // Same cycle write shows up on the read port
    // Covers the decode versus retire conflict
    assign read_data1_o = (read_addr1_i == '0) ? '0 :
                          (write_enable_i && write_addr_i == read_addr1_i) ? write_data_i :
                          regs[read_addr1_i];

    assign read_data2_o = (read_addr2_i == '0) ? '0 :
                          (write_enable_i && write_addr_i == read_addr2_i) ? write_data_i :
                          regs[read_addr2_i];

    // Decode clears the write flag for rd of x0
    // No retire write may arrive aimed at index zero
    x0_never_written: assert property (@(posedge clk) disable iff (!reset_n)
        write_enable_i |-> write_addr_i != '0)
        else $error("register write aimed at x0 reached the bank");

endmodule

// ==== stage_reg.sv ====
/*
 * Pipeline stage register
 * One payload per cycle with hold and bubble insertion
 */

`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t data_i,
    output payload_t data_o
);

    // All zero is the NOP payload
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_o <= '0;
        end
        else if (!hold_i) begin
            if (bubble_i) begin
                data_o <= '0;
            end
            else begin
                data_o <= data_i;
            end
        end
    end

    // Control gates every bubble with the external stall
    hold_bubble_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(hold_i && bubble_i))
        else $error("stage register held and bubbled together");

endmodule

// ==== tb_core.sv ====
/*
 * Core testbench
 * Asynchronous ROM model, stimulus file, random stall and store checks
 */

`timescale 1ns/10ps

module tb_core
    import core_pkg::*;
;

    logic  clk;
    logic  reset_n;
    logic  stall_i;
    word_t instruction;
    word_t instruction_address;
    logic  mem_write;
    word_t mem_address;
    word_t mem_data;

    // Raw file image, program ROM and expected stores
    word_t stim [0:127];
    word_t rom [0:63];
    word_t exp_addr [0:31];
    word_t exp_data [0:31];
    int    prog_count;
    int    exp_count;
    word_t loop_addr;

    // Monitor state
    int          errors;
    int          store_idx;
    int          loop_visits;
    int          cycles_out_of_reset;
    bit          loop_done;
    logic        stall_seen;
    word_t       prev_address;
    logic [64:0] prev_store;
    word_t       rng;
    int          limit;
    int          cycles;

    core_top dut (
        .clk                  (clk),
        .reset_n              (reset_n),
        .stall_i              (stall_i),
        .instruction_i        (instruction),
        .instruction_address_o(instruction_address),
        .mem_write_o          (mem_write),
        .mem_address_o        (mem_address),
        .mem_data_o           (mem_data)
    );

    // Past the program the ROM returns ADDI x0,x0,0
    assign instruction = (int'(instruction_address >> 2) < prog_count) ?
                         rom[instruction_address[7:2]] : nop_instr;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t lcg_next(input word_t state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Count, program words, count, store pairs
    task load_stimulus;
        $readmemh("core_stimulus.mem", stim);
        prog_count = int'(stim[0]);
        for (int i = 0; i < prog_count; i++) begin
            rom[i] = stim[1 + i];
        end
        exp_count = int'(stim[prog_count + 1]);
        for (int i = 0; i < exp_count; i++) begin
            exp_addr[i] = stim[prog_count + 2 + 2 * i];
            exp_data[i] = stim[prog_count + 3 + 2 * i];
        end
        // Last program word is the branch to itself
        loop_addr = word_t'((prog_count - 1) * 4);
    endtask

    task compare_store;
        if (store_idx >= exp_count) begin
            errors++;
            $display("Extra store at %0t: address %h data %h beyond the %0d expected",
                     $time, mem_address, mem_data, exp_count);
        end
        else begin
            if (mem_address !== exp_addr[store_idx]) begin
                errors++;
                $display("Mismatch at %0t: store %0d address %h, expected %h",
                         $time, store_idx, mem_address, exp_addr[store_idx]);
            end
            if (mem_data !== exp_data[store_idx]) begin
                errors++;
                $display("Mismatch at %0t: store %0d data %h, expected %h",
                         $time, store_idx, mem_data, exp_data[store_idx]);
            end
        end
        store_idx++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reset and stall drive, 1 ns after the rising edge
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset_n     = 1'b0;
        stall_i     = 1'b0;
        rng         = 32'd65;
        errors      = 0;
        store_idx   = 0;
        loop_visits = 0;
        loop_done   = 1'b0;
        stall_seen  = 1'b0;
        cycles_out_of_reset = 0;
        load_stimulus();
        repeat (4) @(posedge clk);
        #1 reset_n = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            // Random stall about one cycle in four, second half only
            if (int'(instruction_address >> 2) >= prog_count / 2) begin
                rng     = lcg_next(rng);
                stall_i = rng[17:16] == 2'b00;
            end
            else begin
                stall_i = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Monitor, sampled mid cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        // Reset and the first cycle out of it
        if (!reset_n || cycles_out_of_reset == 0) begin
            if (mem_write !== 1'b0) begin
                errors++;
                $display("Mismatch at %0t: mem_write_o %b around reset", $time, mem_write);
            end
            if (instruction_address !== reset_pc) begin
                errors++;
                $display("Mismatch at %0t: instruction_address_o %h around reset, expected %h",
                         $time, instruction_address, reset_pc);
            end
        end
        if (reset_n) begin
            // Previous cycle stalled, nothing may move
            if (stall_seen) begin
                if (instruction_address !== prev_address) begin
                    errors++;
                    $display("Mismatch at %0t: instruction_address_o %h under stall, was %h",
                             $time, instruction_address, prev_address);
                end
                if ({mem_write, mem_address, mem_data} !== prev_store) begin
                    errors++;
                    $display("Mismatch at %0t: store outputs changed under stall", $time);
                end
            end
            if (mem_write && !stall_i) begin
                compare_store();
            end
            if (!stall_i && instruction_address == loop_addr) begin
                loop_visits++;
            end
            // Several passes means the loop is steady
            if (loop_visits >= 4) begin
                loop_done = 1'b1;
            end
            stall_seen   = stall_i;
            prev_address = instruction_address;
            prev_store   = {mem_write, mem_address, mem_data};
            cycles_out_of_reset++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog and end of run
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        cycles = 0;
        @(posedge reset_n);
        // 40 cycles per program word
        limit = 40 * prog_count;
        while (!loop_done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!loop_done) begin
            errors++;
            $display("Timeout after %0d cycles: self loop never reached, %0d of %0d stores seen",
                     cycles, store_idx, exp_count);
        end
        else if (store_idx != exp_count) begin
            errors++;
            $display("Wrong number of stores at the self loop: %0d seen, %0d expected",
                     store_idx, exp_count);
        end
        $display("Stores checked: %0d of %0d, errors: %0d", store_idx, exp_count, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end
        else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
